// ==== flist.f ====
hw/vgaPkg.sv
hw/vgaTiming.sv
hw/testPattern.sv
hw/cursorOverlay.sv
hw/vgaTop.sv
test/vgaTopTb.sv

// ==== hw/cursorOverlay.sv ====
module cursorOverlay #(
	parameter int CursorSize = 16
) (
	input  logic               clk,
	input  logic               rst,
	input  vgaPkg::displayCfgT cfg,
	input  logic               cfgValid,
	input  vgaPkg::timingT     timingIn,
	input  vgaPkg::rgbT        colorIn,
	output logic               hSync,
	output logic               vSync,
	output vgaPkg::rgbT        rgb
);

	// Pending cursor settings
	logic        pendEn;
	logic [9:0]  pendX;
	logic [9:0]  pendY;
	vgaPkg::rgbT pendColor;
	// Live cursor settings
	logic        liveEn;
	logic [9:0]  liveX;
	logic [9:0]  liveY;
	vgaPkg::rgbT liveColor;
	// Settings seen by the current pixel
	logic        enNow;
	logic [9:0]  xNow;
	logic [9:0]  yNow;
	vgaPkg::rgbT colorNow;
	logic        swapCfg;

	logic [10:0] hPos;
	logic [10:0] vPos;
	logic [10:0] xEnd;
	logic [10:0] yEnd;
	logic        inBox;
	vgaPkg::rgbT rgbNext;

	//////////////////////////////
	// Configuration handoff
	//////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pendEn    <= 1'b0;
			pendX     <= '0;
			pendY     <= '0;
			pendColor <= '0;
		end else if (cfgValid) begin
			pendEn    <= cfg.cursorEn;
			pendX     <= cfg.cursorX;
			pendY     <= cfg.cursorY;
			pendColor <= cfg.cursorColor;
		end
	end

	// Frame start here is the one delayed by the pattern stage
	assign swapCfg  = timingIn.pixelEn && timingIn.frameStart;
	assign enNow    = swapCfg ? pendEn : liveEn;
	assign xNow     = swapCfg ? pendX : liveX;
	assign yNow     = swapCfg ? pendY : liveY;
	assign colorNow = swapCfg ? pendColor : liveColor;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			liveEn    <= 1'b0;
			liveX     <= '0;
			liveY     <= '0;
			liveColor <= '0;
		end else if (swapCfg) begin
			liveEn    <= pendEn;
			liveX     <= pendX;
			liveY     <= pendY;
			liveColor <= pendColor;
		end
	end

	//////////////////////////////
	// Box hit test
	//////////////////////////////

	// Extra bit keeps the far edge from wrapping near 1023
	assign hPos = {1'b0, timingIn.hCount};
	assign vPos = {1'b0, timingIn.vCount};
	assign xEnd = {1'b0, xNow} + 11'(CursorSize);
	assign yEnd = {1'b0, yNow} + 11'(CursorSize);

	assign inBox = enNow
		&& (hPos >= {1'b0, xNow}) && (hPos < xEnd)
		&& (vPos >= {1'b0, yNow}) && (vPos < yEnd);

	// Blanking overrides both cursor and pattern
	always_comb begin
		if (!timingIn.active) begin
			rgbNext = '0;
		end else if (inBox) begin
			rgbNext = colorNow;
		end else begin
			rgbNext = colorIn;
		end
	end

	//////////////////////////////
	// Output register
	//////////////////////////////

	// Sync rides along so it stays aligned with colour
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hSync <= 1'b0;
			vSync <= 1'b0;
			rgb   <= '0;
		end else if (timingIn.pixelEn) begin
			hSync <= timingIn.hSync;
			vSync <= timingIn.vSync;
			rgb   <= rgbNext;
		end
	end

endmodule

// ==== hw/testPattern.sv ====
module testPattern #(
	parameter int TileShift = 6
) (
	input  logic               clk,
	input  logic               rst,
	input  vgaPkg::displayCfgT cfg,
	input  logic               cfgValid,
	input  vgaPkg::timingT     timingIn,
	output vgaPkg::timingT     timingOut,
	output vgaPkg::rgbT        color
);

	// Pending copy waits here until the next frame
	vgaPkg::patternModeT pendMode;
	vgaPkg::rgbT         pendSolid;
	// Copy used for the frame in progress
	vgaPkg::patternModeT liveMode;
	vgaPkg::rgbT         liveSolid;
	// Settings seen by the current pixel
	vgaPkg::patternModeT modeNow;
	vgaPkg::rgbT         solidNow;
	logic                swapCfg;

	logic [9:0]     hTile;
	logic [9:0]     vTile;
	logic [2:0]     barIdx;
	logic           checkOn;
	vgaPkg::rgbT    colorNext;
	vgaPkg::timingT timingReg;

	//////////////////////////////
	// Configuration handoff
	//////////////////////////////

	// Latest strobe wins
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pendMode  <= vgaPkg::PatSolid;
			pendSolid <= '0;
		end else if (cfgValid) begin
			pendMode  <= cfg.mode;
			pendSolid <= cfg.solidColor;
		end
	end

	// Swap on the enabled cycle of pixel 0,0
	assign swapCfg  = timingIn.pixelEn && timingIn.frameStart;
	// First pixel of the frame already uses the new settings
	assign modeNow  = swapCfg ? pendMode : liveMode;
	assign solidNow = swapCfg ? pendSolid : liveSolid;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			liveMode  <= vgaPkg::PatSolid;
			liveSolid <= '0;
		end else if (swapCfg) begin
			liveMode  <= pendMode;
			liveSolid <= pendSolid;
		end
	end

	//////////////////////////////
	// Colour generation
	//////////////////////////////

	assign hTile   = timingIn.hCount >> TileShift;
	assign vTile   = timingIn.vCount >> TileShift;
	// Eight bars repeat across the line
	assign barIdx  = hTile[2:0];
	assign checkOn = hTile[0] ^ vTile[0];

	always_comb begin
		case (modeNow)
			vgaPkg::PatSolid: begin
				colorNext = solidNow;
			end
			vgaPkg::PatBars: begin
				colorNext.red   = {4{barIdx[2]}};
				colorNext.green = {4{barIdx[1]}};
				colorNext.blue  = {4{barIdx[0]}};
			end
			vgaPkg::PatChecker: begin
				colorNext.red   = {4{checkOn}};
				colorNext.green = {4{checkOn}};
				colorNext.blue  = {4{checkOn}};
			end
			vgaPkg::PatGradient: begin
				// Ramp repeats every 16 pixels
				colorNext.red   = timingIn.hCount[3:0];
				colorNext.green = timingIn.vCount[3:0];
				colorNext.blue  = 4'd0;
			end
			default: begin
				colorNext = '0;
			end
		endcase
	end

	//////////////////////////////
	// Stage register
	//////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			timingReg <= '0;
			color     <= '0;
		end else if (timingIn.pixelEn) begin
			timingReg <= timingIn;
			color     <= colorNext;
		end
	end

	// Enable is passed through live, the rest is one pixel late
	always_comb begin
		timingOut         = timingReg;
		timingOut.pixelEn = timingIn.pixelEn;
	end

endmodule

// ==== hw/vgaPkg.sv ====
package vgaPkg;

	//////////////////////////////
	// Pixel and raster types
	//////////////////////////////

	// Twelve-bit colour, four bits per channel
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgbT;

	// Raster state handed from stage to stage
	typedef struct packed {
		logic [9:0] hCount;
		logic [9:0] vCount;
		logic       hSync;
		logic       vSync;
		// Inside the visible window
		logic       active;
		// Pixel 0,0 of a frame
		logic       frameStart;
		// Stage advances on this cycle
		logic       pixelEn;
	} timingT;

	//////////////////////////////
	// Configuration
	//////////////////////////////

	typedef enum logic [1:0] {
		PatSolid    = 2'd0,
		PatBars     = 2'd1,
		PatChecker  = 2'd2,
		PatGradient = 2'd3
	} patternModeT;

	// One word carries both pattern and cursor settings
	typedef struct packed {
		patternModeT mode;
		rgbT         solidColor;
		logic        cursorEn;
		logic [9:0]  cursorX;
		logic [9:0]  cursorY;
		rgbT         cursorColor;
	} displayCfgT;

	// 640x480 at 60 Hz, 25.175 MHz pixel clock
	localparam logic [9:0] DefHActive = 10'd640;
	localparam logic [9:0] DefHFront  = 10'd16;
	localparam logic [9:0] DefHSync   = 10'd96;
	localparam logic [9:0] DefHBack   = 10'd48;
	localparam logic [9:0] DefVActive = 10'd480;
	localparam logic [9:0] DefVFront  = 10'd10;
	localparam logic [9:0] DefVSync   = 10'd2;
	localparam logic [9:0] DefVBack   = 10'd33;

endpackage

// ==== hw/vgaTiming.sv ====
module vgaTiming #(
	parameter int HActive = vgaPkg::DefHActive,
	parameter int HFront  = vgaPkg::DefHFront,
	parameter int HSync   = vgaPkg::DefHSync,
	parameter int HBack   = vgaPkg::DefHBack,
	parameter int VActive = vgaPkg::DefVActive,
	parameter int VFront  = vgaPkg::DefVFront,
	parameter int VSync   = vgaPkg::DefVSync,
	parameter int VBack   = vgaPkg::DefVBack,
	parameter int ClkDiv  = 2
) (
	input  logic           clk,
	input  logic           rst,
	output vgaPkg::timingT timing
);

	//////////////////////////////
	// Geometry decode points
	//////////////////////////////

	// Retrace windows follow the front porch
	localparam logic [9:0] HSyncStart = 10'(HActive + HFront);
	localparam logic [9:0] HSyncEnd   = 10'(HActive + HFront + HSync - 1);
	localparam logic [9:0] HLast      = 10'(HActive + HFront + HSync + HBack - 1);
	localparam logic [9:0] VSyncStart = 10'(VActive + VFront);
	localparam logic [9:0] VSyncEnd   = 10'(VActive + VFront + VSync - 1);
	localparam logic [9:0] VLast      = 10'(VActive + VFront + VSync + VBack - 1);
	localparam logic [9:0] HVisible   = 10'(HActive);
	localparam logic [9:0] VVisible   = 10'(VActive);

	// Divider needs at least one bit even for ClkDiv of 1
	localparam int DivW = (ClkDiv > 1) ? $clog2(ClkDiv) : 1;
	localparam logic [DivW-1:0] DivLast = DivW'(ClkDiv - 1);

	logic [DivW-1:0] divCount;
	logic            pixelEn;
	logic [9:0]      hCount;
	logic [9:0]      vCount;
	logic            hEnd;
	logic            vEnd;

	//////////////////////////////
	// Pixel enable
	//////////////////////////////

	// One pulse every ClkDiv clocks
	assign pixelEn = (divCount == DivLast);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			divCount <= '0;
		end else if (pixelEn) begin
			divCount <= '0;
		end else begin
			divCount <= divCount + 1'b1;
		end
	end

	//////////////////////////////
	// Raster counters
	//////////////////////////////

	assign hEnd = (hCount == HLast);
	assign vEnd = (vCount == VLast);

	// Line counter steps once per horizontal wrap
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hCount <= '0;
			vCount <= '0;
		end else if (pixelEn) begin
			if (hEnd) begin
				hCount <= '0;
				if (vEnd) begin
					vCount <= '0;
				end else begin
					vCount <= vCount + 10'd1;
				end
			end else begin
				hCount <= hCount + 10'd1;
			end
		end
	end

	//////////////////////////////
	// Sync and flag decode
	//////////////////////////////

	// Straight from the counters, no extra delay
	always_comb begin
		timing.hCount     = hCount;
		timing.vCount     = vCount;
		// Sync high during retrace
		timing.hSync      = (hCount >= HSyncStart) && (hCount <= HSyncEnd);
		timing.vSync      = (vCount >= VSyncStart) && (vCount <= VSyncEnd);
		timing.active     = (hCount < HVisible) && (vCount < VVisible);
		timing.frameStart = (hCount == 10'd0) && (vCount == 10'd0);
		timing.pixelEn    = pixelEn;
	end

endmodule

// ==== hw/vgaTop.sv ====
module vgaTop #(
	parameter int HActive    = vgaPkg::DefHActive,
	parameter int HFront     = vgaPkg::DefHFront,
	parameter int HSync      = vgaPkg::DefHSync,
	parameter int HBack      = vgaPkg::DefHBack,
	parameter int VActive    = vgaPkg::DefVActive,
	parameter int VFront     = vgaPkg::DefVFront,
	parameter int VSync      = vgaPkg::DefVSync,
	parameter int VBack      = vgaPkg::DefVBack,
	// Clocks per pixel, 2 gives 25 MHz from 50 MHz
	parameter int ClkDiv     = 2,
	// 64-pixel bars and tiles
	parameter int TileShift  = 6,
	parameter int CursorSize = 16
) (
	input  logic               clk,
	input  logic               rst,
	input  vgaPkg::displayCfgT cfg,
	input  logic               cfgValid,
	output logic               hSync,
	output logic               vSync,
	output vgaPkg::rgbT        rgb
);

	// Raster straight from the counters
	vgaPkg::timingT rasterTiming;
	// Raster one pixel behind, aligned with the pattern colour
	vgaPkg::timingT patTiming;
	vgaPkg::rgbT    patColor;

	//////////////////////////////
	// Pipeline
	//////////////////////////////

	vgaTiming #(
		.HActive(HActive),
		.HFront (HFront),
		.HSync  (HSync),
		.HBack  (HBack),
		.VActive(VActive),
		.VFront (VFront),
		.VSync  (VSync),
		.VBack  (VBack),
		.ClkDiv (ClkDiv)
	) timingGen (
		.clk   (clk),
		.rst   (rst),
		.timing(rasterTiming)
	);

	testPattern #(
		.TileShift(TileShift)
	) patternGen (
		.clk      (clk),
		.rst      (rst),
		.cfg      (cfg),
		.cfgValid (cfgValid),
		.timingIn (rasterTiming),
		.timingOut(patTiming),
		.color    (patColor)
	);

	// Last stage drives the pins
	cursorOverlay #(
		.CursorSize(CursorSize)
	) overlay (
		.clk     (clk),
		.rst     (rst),
		.cfg     (cfg),
		.cfgValid(cfgValid),
		.timingIn(patTiming),
		.colorIn (patColor),
		.hSync   (hSync),
		.vSync   (vSync),
		.rgb     (rgb)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the VGA testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=vgaTopTb
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
	--top-module vgaTopTb \
	--Mdir "$BUILD_DIR" -o "$SIM_BIN" \
	-f flist.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Only an exact pass line in the log counts
if grep -qx "sim passed" "$LOG"; then
	exit 0
else
	echo "Pass line not found in $LOG"
	exit 1
fi

// ==== test/vgaTopTb.sv ====
module vgaTopTb;

	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////
	// Small raster for fast frames
	//////////////////////////////

	localparam int HActive    = 16;
	localparam int HFront     = 2;
	localparam int HSync      = 3;
	localparam int HBack      = 3;
	localparam int VActive    = 8;
	localparam int VFront     = 1;
	localparam int VSync      = 2;
	localparam int VBack      = 2;
	localparam int ClkDiv     = 2;
	localparam int TileShift  = 2;
	localparam int CursorSize = 3;

	localparam int HTotal      = HActive + HFront + HSync + HBack;
	localparam int VTotal      = VActive + VFront + VSync + VBack;
	localparam int FramePixels = HTotal * VTotal;
	// Longer than one full frame in clocks
	localparam int WaitLimit   = 3 * FramePixels * ClkDiv;
	localparam int ResetCycles = 10;
	// Pins position where mid-frame strobes go out
	localparam int MidH = 5;
	localparam int MidV = 3;

	// One table row, probe is a hand-worked pixel of the new frames
	typedef struct {
		vgaPkg::displayCfgT cfg;
		int                 frames;
		bit                 midFrame;
		bit                 twice;
		int                 probeH;
		int                 probeV;
		vgaPkg::rgbT        probe;
	} stimRowT;

	logic               clk;
	logic               rst;
	vgaPkg::displayCfgT cfg;
	logic               cfgValid;
	logic               hSync;
	logic               vSync;
	vgaPkg::rgbT        rgb;

	stimRowT            rows[$];
	integer             seed = 32'hcbf8_9127;
	int                 errorCount = 0;
	int                 checkCount = 0;
	// Model position of the pixel now on the pins
	int                 h;
	int                 v;
	vgaPkg::displayCfgT liveCfg;
	vgaPkg::displayCfgT pendCfg;
	// Handoff to the strobe driver
	vgaPkg::displayCfgT strobeCfg;
	int                 strobeReq = 0;
	int                 strobeAck;
	bit                 probeArmed = 1'b0;
	int                 probeH;
	int                 probeV;
	vgaPkg::rgbT        probeColor;
	bit                 found;

	vgaTop #(
		.HActive   (HActive),
		.HFront    (HFront),
		.HSync     (HSync),
		.HBack     (HBack),
		.VActive   (VActive),
		.VFront    (VFront),
		.VSync     (VSync),
		.VBack     (VBack),
		.ClkDiv    (ClkDiv),
		.TileShift (TileShift),
		.CursorSize(CursorSize)
	) UUT (
		.clk     (clk),
		.rst     (rst),
		.cfg     (cfg),
		.cfgValid(cfgValid),
		.hSync   (hSync),
		.vSync   (vSync),
		.rgb     (rgb)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// One cfgValid pulse per request, on the rising edge
	initial begin
		cfg       <= '0;
		cfgValid  <= 1'b0;
		strobeAck <= 0;
		forever begin
			@(posedge clk);
			if (strobeAck != strobeReq) begin
				cfg       <= strobeCfg;
				cfgValid  <= 1'b1;
				strobeAck <= strobeAck + 1;
			end else begin
				cfgValid <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic vgaPkg::displayCfgT makeCfg(input vgaPkg::patternModeT mode,
		input logic [11:0] solid, input logic en, input logic [9:0] x,
		input logic [9:0] y, input logic [11:0] curColor);
		vgaPkg::displayCfgT c;
		c.mode        = mode;
		c.solidColor  = solid;
		c.cursorEn    = en;
		c.cursorX     = x;
		c.cursorY     = y;
		c.cursorColor = curColor;
		return c;
	endfunction

	function automatic vgaPkg::displayCfgT randomCfg(input vgaPkg::patternModeT mode);
		logic [31:0] r1;
		logic [31:0] r2;
		r1 = $random(seed);
		r2 = $random(seed);
		// Box corner anywhere visible, may run past the edges
		return makeCfg(mode, r1[11:0], 1'b1, {6'd0, r1[15:12]}, {7'd0, r1[18:16]}, r2[11:0]);
	endfunction

	function automatic vgaPkg::rgbT expectColor(input int px, input int py,
		input vgaPkg::displayCfgT c);
		vgaPkg::rgbT e;
		int cx;
		int cy;
		int tile;
		cx = int'(c.cursorX);
		cy = int'(c.cursorY);
		e  = '0;
		// Blanking beats everything
		if (px >= HActive || py >= VActive) begin
			e = '0;
		end else if (c.cursorEn && px >= cx && px < cx + CursorSize
			&& py >= cy && py < cy + CursorSize) begin
			e = c.cursorColor;
		end else begin
			case (c.mode)
				vgaPkg::PatSolid: begin
					e = c.solidColor;
				end
				vgaPkg::PatBars: begin
					tile    = (px >> TileShift) % 8;
					e.red   = ((tile & 4) != 0) ? 4'hf : 4'h0;
					e.green = ((tile & 2) != 0) ? 4'hf : 4'h0;
					e.blue  = ((tile & 1) != 0) ? 4'hf : 4'h0;
				end
				vgaPkg::PatChecker: begin
					tile = ((px >> TileShift) ^ (py >> TileShift)) & 1;
					e    = (tile == 1) ? 12'hfff : 12'h000;
				end
				vgaPkg::PatGradient: begin
					e.red   = 4'(px % 16);
					e.green = 4'(py % 16);
					e.blue  = 4'h0;
				end
			endcase
		end
		return e;
	endfunction

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic checkBit(input string name, input string pos, input logic expVal,
		input logic actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errorCount++;
			$display("FAILED at %0t: %s (%s) expected %b, got %b", $time, name, pos, expVal,
				actVal);
		end
	endtask

	task automatic checkColor(input string name, input string pos, input vgaPkg::rgbT expVal,
		input vgaPkg::rgbT actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errorCount++;
			$display("FAILED at %0t: %s (%s) expected %h, got %h", $time, name, pos, expVal,
				actVal);
		end
	endtask

	task automatic checkZero(input string pos);
		checkBit("hSync", pos, 1'b0, hSync);
		checkBit("vSync", pos, 1'b0, vSync);
		checkColor("rgb", pos, 12'h000, rgb);
	endtask

	task automatic checkPixel();
		string pos;
		logic  expH;
		logic  expV;
		pos  = $sformatf("pixel %0d,%0d", h, v);
		expH = (h >= HActive + HFront) && (h < HActive + HFront + HSync);
		expV = (v >= VActive + VFront) && (v < VActive + VFront + VSync);
		checkBit("hSync", pos, expH, hSync);
		checkBit("vSync", pos, expV, vSync);
		checkColor("rgb", pos, expectColor(h, v, liveCfg), rgb);
		if (probeArmed && h == probeH && v == probeV) begin
			checkColor("rgb probe", pos, probeColor, rgb);
		end
	endtask

	// Next pixel reaches the pins ClkDiv clocks later
	task automatic stepPixel();
		repeat (ClkDiv) @(negedge clk);
		h++;
		if (h == HTotal) begin
			h = 0;
			v++;
			if (v == VTotal) begin
				v = 0;
			end
		end
		// Frame start takes the latest pending setup
		if (h == 0 && v == 0) begin
			liveCfg = pendCfg;
		end
		checkPixel();
	endtask

	task automatic runUntil(input int th, input int tv);
		while (h != th || v != tv) begin
			stepPixel();
		end
	endtask

	task automatic runPixels(input int n);
		repeat (n) stepPixel();
	endtask

	task automatic requestCfg(input vgaPkg::displayCfgT c);
		pendCfg   = c;
		strobeCfg = c;
		strobeReq++;
	endtask

	//////////////////////////////
	// Sync search and measurement
	//////////////////////////////

	task automatic waitLevel(input bit useV, input bit level, output int clocks, output bit got);
		bit cur;
		clocks = 0;
		got    = 1'b0;
		while (!got && clocks < WaitLimit) begin
			@(negedge clk);
			clocks++;
			cur = useV ? vSync : hSync;
			if (cur == level) begin
				got = 1'b1;
			end
		end
	endtask

	task automatic measureSync(output bit done);
		bit    useV;
		bit    got;
		string name;
		int    skip;
		int    highClk;
		int    lowClk;
		int    expHigh;
		int    expPeriod;
		done = 1'b1;
		for (int sel = 0; sel < 2 && done; sel++) begin
			useV      = (sel == 1);
			name      = useV ? "vSync" : "hSync";
			expHigh   = useV ? VSync * HTotal * ClkDiv : HSync * ClkDiv;
			expPeriod = useV ? FramePixels * ClkDiv : HTotal * ClkDiv;
			highClk   = 0;
			lowClk    = 0;
			waitLevel(useV, 1'b0, skip, got);
			if (got) begin
				waitLevel(useV, 1'b1, skip, got);
			end
			if (got) begin
				waitLevel(useV, 1'b0, highClk, got);
			end
			if (got) begin
				waitLevel(useV, 1'b1, lowClk, got);
			end
			if (!got) begin
				$display("Timeout: %s did not toggle within %0d clocks", name, WaitLimit);
				errorCount++;
				done = 1'b0;
			end else begin
				checkCount += 2;
				if (highClk != expHigh) begin
					errorCount++;
					$display("FAILED at %0t: %s width expected %0d clocks, got %0d", $time, name,
						expHigh, highClk);
				end
				if (highClk + lowClk != expPeriod) begin
					errorCount++;
					$display("FAILED at %0t: %s period expected %0d clocks, got %0d", $time, name,
						expPeriod, highClk + lowClk);
				end
			end
		end
	endtask

	// Rising vSync on the pins is pixel 0 of line VActive+VFront
	task automatic alignToFrame(output bit done);
		int skip;
		waitLevel(1'b1, 1'b0, skip, done);
		if (done) begin
			waitLevel(1'b1, 1'b1, skip, done);
		end
		if (!done) begin
			$display("Timeout: no rising vSync edge, raster position unknown");
			errorCount++;
		end else begin
			h       = 0;
			v       = VActive + VFront;
			liveCfg = '0;
			pendCfg = '0;
			checkPixel();
		end
	endtask

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	task automatic addRow(input vgaPkg::displayCfgT c, input int frames, input bit midFrame,
		input bit twice, input int ph, input int pv, input logic [11:0] probe);
		stimRowT row;
		row.cfg      = c;
		row.frames   = frames;
		row.midFrame = midFrame;
		row.twice    = twice;
		row.probeH   = ph;
		row.probeV   = pv;
		row.probe    = probe;
		rows.push_back(row);
	endtask

	task automatic buildTable();
		// Disabled cursor sits over the probe
		addRow(makeCfg(vgaPkg::PatSolid, 12'ha5c, 1'b0, 10'd2, 10'd2, 12'hf00),
			1, 1'b0, 1'b0, 3, 2, 12'ha5c);
		addRow(makeCfg(vgaPkg::PatBars, 12'h000, 1'b0, 10'd0, 10'd0, 12'h000),
			1, 1'b1, 1'b0, 13, 1, 12'h0ff);
		addRow(makeCfg(vgaPkg::PatChecker, 12'h000, 1'b0, 10'd0, 10'd0, 12'h000),
			1, 1'b0, 1'b0, 5, 1, 12'hfff);
		addRow(makeCfg(vgaPkg::PatGradient, 12'h000, 1'b1, 10'd5, 10'd3, 12'hf0f),
			2, 1'b1, 1'b0, 6, 4, 12'hf0f);
		// Box clipped by the right and bottom edges
		addRow(makeCfg(vgaPkg::PatBars, 12'h000, 1'b1, 10'd14, 10'd6, 12'h8a1),
			1, 1'b0, 1'b0, 15, 7, 12'h8a1);
		// Second strobe of the frame must win
		addRow(makeCfg(vgaPkg::PatGradient, 12'h000, 1'b0, 10'd0, 10'd0, 12'h000),
			1, 1'b1, 1'b1, 9, 7, 12'h970);
		addRow(randomCfg(vgaPkg::PatSolid), 1, 1'b0, 1'b0, HActive + 1, 2, 12'h000);
		addRow(randomCfg(vgaPkg::PatSolid), 1, 1'b1, 1'b0, HActive + 1, 2, 12'h000);
		addRow(makeCfg(vgaPkg::PatChecker, 12'h000, 1'b1, 10'd0, 10'd0, 12'h0f0),
			1, 1'b0, 1'b0, 0, 0, 12'h0f0);
	endtask

	task automatic runTable();
		foreach (rows[r]) begin
			// Strobe far from any frame start
			if (rows[r].midFrame) begin
				runUntil(MidH, MidV);
			end else begin
				runUntil(0, VActive + VFront);
			end
			if (rows[r].twice) begin
				requestCfg(randomCfg(vgaPkg::PatChecker));
				runPixels(4);
			end
			requestCfg(rows[r].cfg);
			// Rest of this frame keeps the old setup
			runUntil(0, 0);
			probeH     = rows[r].probeH;
			probeV     = rows[r].probeV;
			probeColor = rows[r].probe;
			probeArmed = 1'b1;
			runPixels(rows[r].frames * FramePixels);
			probeArmed = 1'b0;
		end
	endtask

	initial begin
		rst       <= 1'b1;
		h         = 0;
		v         = 0;
		liveCfg   = '0;
		pendCfg   = '0;
		strobeCfg = '0;
		buildTable();
		repeat (ResetCycles) begin
			@(negedge clk);
			checkZero("during reset");
		end
		@(posedge clk);
		rst <= 1'b0;
		repeat (8) begin
			@(negedge clk);
			checkZero("after reset");
		end
		measureSync(found);
		if (found) begin
			alignToFrame(found);
		end
		if (found) begin
			runTable();
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
